/* common/nts_dispatcher_params.svh */
/*
 * Bank and MAC word widths, register map offsets and core identity
 */
`ifndef NTS_DISPATCHER_PARAMS_SVH
`define NTS_DISPATCHER_PARAMS_SVH

`define NTS_ADDR_WIDTH     8    // 256 words per bank
`define NTS_DATA_WIDTH     64
`define NTS_API_ADDR_WIDTH 12

`define NTS_CORE_NAME    64'h4e54_532d_4449_5350 // NTS-DISP
`define NTS_CORE_VERSION 32'h302e_3031           // 0.01

`define NTS_ADDR_NAME0           12'h000
`define NTS_ADDR_NAME1           12'h001
`define NTS_ADDR_VERSION         12'h002
`define NTS_ADDR_BYTES_RX_MSB    12'h00a
`define NTS_ADDR_BYTES_RX_LSB    12'h00b
`define NTS_ADDR_FRAMES_MSB      12'h020
`define NTS_ADDR_FRAMES_LSB      12'h021
`define NTS_ADDR_GOOD_MSB        12'h022
`define NTS_ADDR_GOOD_LSB        12'h023
`define NTS_ADDR_BAD_MSB         12'h024
`define NTS_ADDR_BAD_LSB         12'h025
`define NTS_ADDR_DISPATCHED_MSB  12'h026
`define NTS_ADDR_DISPATCHED_LSB  12'h027

`endif

/* common/nts_dispatcher_pkg.sv */
/*
 * Packed struct types shared by the frame dispatcher blocks:
 * MAC beat, bank write, frame descriptor and dispatch word
 */
`include "nts_dispatcher_params.svh"

package nts_dispatcher_pkg;

  // One MAC receive cycle
  typedef struct packed {
    logic [7:0]                 data_valid;  // One bit per byte, low aligned on the tail
    logic [`NTS_DATA_WIDTH-1:0] data;
    logic                       bad_frame;
    logic                       good_frame;  // Comes with the last beat
  } rx_beat_t;

  // One word written into the current write bank
  typedef struct packed {
    logic                       strobe;
    logic [`NTS_ADDR_WIDTH-1:0] addr;
    logic [`NTS_DATA_WIDTH-1:0] data;
  } bank_write_t;

  // Descriptor of a stored frame
  typedef struct packed {
    logic [`NTS_ADDR_WIDTH-1:0] last_addr;
    logic [7:0]                 data_valid;  // Valid bytes of the last word
  } frame_info_t;

  // One word handed to the downstream engine
  typedef struct packed {
    logic                       valid;
    logic [`NTS_DATA_WIDTH-1:0] data;
  } dispatch_word_t;

endpackage

/* rtl/nts_rx_capture.sv */
/*
 * MAC receive capture: start-of-frame detection, tail word alignment
 * and write sequencing into the frame store
 */
`include "nts_dispatcher_params.svh"

module nts_rx_capture (
  input  logic                              i_clk,
  input  logic                              i_areset,
  input  nts_dispatcher_pkg::rx_beat_t      i_beat,
  input  logic                              i_wr_ready,
  output nts_dispatcher_pkg::bank_write_t   o_write,
  output logic                              o_commit,
  output logic                              o_abort,
  output nts_dispatcher_pkg::frame_info_t   o_info,
  output logic                              o_start_of_frame,
  output logic [3:0]                        o_bytes
);

  localparam logic [`NTS_ADDR_WIDTH-1:0] LAST_ADDR = '1;

  logic [7:0]                 prev_valid;
  logic                       in_frame;
  logic [`NTS_ADDR_WIDTH-1:0] word_cnt;     // Address of the last word written
  logic                       accept_start;
  logic                       active;
  logic                       take;
  logic [`NTS_ADDR_WIDTH-1:0] next_addr;
  logic [`NTS_DATA_WIDTH-1:0] aligned;
  logic                       wr_strobe;
  logic [`NTS_ADDR_WIDTH-1:0] wr_addr;
  logic [`NTS_DATA_WIDTH-1:0] wr_data;

  // Valid byte count of the beat
  always_comb
  begin
    case (i_beat.data_valid)
      8'hff:   o_bytes = 4'd8;
      8'h7f:   o_bytes = 4'd7;
      8'h3f:   o_bytes = 4'd6;
      8'h1f:   o_bytes = 4'd5;
      8'h0f:   o_bytes = 4'd4;
      8'h07:   o_bytes = 4'd3;
      8'h03:   o_bytes = 4'd2;
      8'h01:   o_bytes = 4'd1;
      8'h00:   o_bytes = 4'd0;
      default: o_bytes = 4'd8;  // Not a tail pattern, word kept as is
    endcase
  end

  // Valid low bytes move to the top, zeros fill below
  assign aligned = i_beat.data << (7'd64 - {o_bytes, 3'b000});

  assign o_start_of_frame = (prev_valid == 8'h00) && (i_beat.data_valid == 8'hff);
  assign accept_start     = o_start_of_frame && i_wr_ready;
  assign active           = in_frame || accept_start;
  assign next_addr        = accept_start ? '0 : word_cnt + 1'b1;

  // Words past the end of the bank are dropped
  assign take = active && i_wr_ready && !i_beat.bad_frame && (i_beat.data_valid != 8'h00) &&
                (accept_start || (word_cnt != LAST_ADDR));

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      prev_valid <= 8'hff;  // Nonzero so reset gives no false start
      in_frame   <= 1'b0;
      word_cnt   <= '0;
      wr_strobe  <= 1'b0;
      o_commit   <= 1'b0;
      o_abort    <= 1'b0;
    end
    else
    begin
      prev_valid <= i_beat.data_valid;
      wr_strobe  <= take;
      o_commit   <= active && i_wr_ready && i_beat.good_frame && !i_beat.bad_frame;
      o_abort    <= active && i_beat.bad_frame;
      if (take)
        word_cnt <= next_addr;
      if (i_beat.bad_frame || i_beat.good_frame)
        in_frame <= 1'b0;
      else if (accept_start)
        in_frame <= 1'b1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    wr_addr           <= next_addr;
    wr_data           <= aligned;
    o_info.last_addr  <= take ? next_addr : word_cnt;  // Overrun keeps the saturated address
    o_info.data_valid <= i_beat.data_valid;
  end

  assign o_write = '{strobe: wr_strobe, addr: wr_addr, data: wr_data};

endmodule

/* rtl/frame_store/nts_dispatch_reader.sv */
/*
 * Dispatch reader FSM: waits for a start, primes the bank read,
 * streams the stored words and holds until the frame is discarded
 */
`include "nts_dispatcher_params.svh"

module nts_dispatch_reader (
  input  logic                                i_clk,
  input  logic                                i_areset,
  input  logic                                i_packet_available,
  input  nts_dispatcher_pkg::frame_info_t     i_info,
  input  logic [`NTS_DATA_WIDTH-1:0]          i_rd_data,
  input  logic                                i_rd_start,
  input  logic                                i_read_discard,
  output logic [`NTS_ADDR_WIDTH-1:0]          o_rd_addr,
  output logic                                o_release,
  output logic                                o_fifo_empty,
  output nts_dispatcher_pkg::dispatch_word_t  o_word
);

  typedef enum logic [1:0] {RD_IDLE, RD_PRIME, RD_STREAM, RD_DONE} rd_state_t;

  rd_state_t                  state;
  logic [`NTS_ADDR_WIDTH-1:0] out_cnt;      // Index of the word going out
  logic                       word_valid;
  logic [`NTS_DATA_WIDTH-1:0] word_data;

  assign o_release = i_read_discard;  // Frees the read bank from any state

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state        <= RD_IDLE;
      o_rd_addr    <= '0;
      out_cnt      <= '0;
      word_valid   <= 1'b0;
      o_fifo_empty <= 1'b1;
    end
    else if (i_read_discard)
    begin
      state        <= RD_IDLE;
      word_valid   <= 1'b0;
      o_fifo_empty <= 1'b1;
    end
    else
    begin
      case (state)
        RD_IDLE:
        begin
          o_fifo_empty <= !i_packet_available;
          o_rd_addr    <= '0;
          out_cnt      <= '0;
          if (i_packet_available && i_rd_start)
            state <= RD_PRIME;
        end
        RD_PRIME:
        begin
          o_rd_addr <= o_rd_addr + 1'b1;  // Bank is reading word 0 now
          state     <= RD_STREAM;
        end
        RD_STREAM:
        begin
          word_valid <= 1'b1;
          o_rd_addr  <= o_rd_addr + 1'b1;
          if (out_cnt == i_info.last_addr)
            state <= RD_DONE;
          else
            out_cnt <= out_cnt + 1'b1;
        end
        default:
        begin
          // Hold here until discard
          word_valid   <= 1'b0;
          o_fifo_empty <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    word_data <= i_rd_data;
  end

  assign o_word = '{valid: word_valid, data: word_data};

endmodule

/* rtl/frame_store/nts_frame_store.sv */
/*
 * Two ping-pong frame banks with per-bank ownership states and the
 * swap rule, plus the dispatch reader that empties the read bank
 */
`include "nts_dispatcher_params.svh"

module nts_frame_store (
  input  logic                                i_clk,
  input  logic                                i_areset,
  input  nts_dispatcher_pkg::bank_write_t     i_write,
  input  logic                                i_commit,
  input  logic                                i_abort,
  input  nts_dispatcher_pkg::frame_info_t     i_info,
  input  logic                                i_rd_start,
  input  logic                                i_read_discard,
  output logic                                o_wr_ready,
  output logic                                o_packet_available,
  output nts_dispatcher_pkg::frame_info_t     o_frame_info,
  output logic                                o_fifo_empty,
  output nts_dispatcher_pkg::dispatch_word_t  o_word
);

  localparam int AW = `NTS_ADDR_WIDTH;
  localparam int DW = `NTS_DATA_WIDTH;

  typedef enum logic [1:0] {BANK_EMPTY, BANK_FILLING, BANK_FULL, BANK_READ} bank_state_t;

  bank_state_t                     state [2];
  logic                            wbank;        // Bank owned by the MAC side
  logic                            rbank;
  logic                            swap;
  nts_dispatcher_pkg::frame_info_t info [2];
  logic [1:0]                      bank_we;
  logic [AW-1:0]                   bank_addr [2];
  logic [DW-1:0]                   bank_q [2];
  logic [AW-1:0]                   r_addr;
  logic [DW-1:0]                   rd_data;
  logic                            rd_release;

  assign rbank = ~wbank;
  assign swap  = (state[wbank] == BANK_FULL) && (state[rbank] == BANK_EMPTY);

  // A full bank still takes a new frame when the swap is on this edge
  assign o_wr_ready = (state[wbank] != BANK_FULL) || swap;

  // ------------------------------------------------------------------------
  // Single-port banks, write has the port, otherwise the reader address
  // ------------------------------------------------------------------------
  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    logic [DW-1:0] mem [2**AW];

    assign bank_we[b]   = i_write.strobe && (wbank == 1'(b));
    assign bank_addr[b] = bank_we[b] ? i_write.addr : r_addr;

    always_ff @(posedge i_clk)
    begin
      if (bank_we[b])
        mem[bank_addr[b]] <= i_write.data;
      bank_q[b] <= mem[bank_addr[b]];
    end
  end

  // ------------------------------------------------------------------------
  // Bank ownership
  // ------------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state[0] <= BANK_EMPTY;
      state[1] <= BANK_EMPTY;
      wbank    <= 1'b0;
    end
    else
    begin
      if (i_abort)
        state[wbank] <= BANK_EMPTY;  // Bad frame dropped
      else if (i_commit)
        state[wbank] <= BANK_FULL;
      else if (i_write.strobe && (state[wbank] == BANK_EMPTY))
        state[wbank] <= BANK_FILLING;
      if (rd_release)
        state[rbank] <= BANK_EMPTY;
      if (swap)
      begin
        state[wbank] <= BANK_READ;   // Committed frame goes to the reader
        wbank        <= rbank;
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_commit)
      info[wbank] <= i_info;
  end

  assign o_packet_available = (state[rbank] == BANK_READ);
  assign o_frame_info       = info[rbank];
  assign rd_data            = bank_q[rbank];

  nts_dispatch_reader u_reader (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_packet_available (o_packet_available),
    .i_info             (info[rbank]),
    .i_rd_data          (rd_data),
    .i_rd_start         (i_rd_start),
    .i_read_discard     (i_read_discard),
    .o_rd_addr          (r_addr),
    .o_release          (rd_release),
    .o_fifo_empty       (o_fifo_empty),
    .o_word             (o_word)
  );

endmodule

/* rtl/nts_rx_statistics.sv */
/*
 * Receive statistics: 64-bit event counters with LSB snapshots
 * and the read-only register window
 */
`include "nts_dispatcher_params.svh"

module nts_rx_statistics (
  input  logic                              i_clk,
  input  logic                              i_areset,
  input  nts_dispatcher_pkg::rx_beat_t      i_beat,
  input  logic                              i_start_of_frame,
  input  logic [3:0]                        i_bytes,
  input  logic                              i_rd_start,
  input  logic                              i_api_cs,
  input  logic [`NTS_API_ADDR_WIDTH-1:0]    i_api_address,
  output logic [31:0]                       o_api_read_data
);

  localparam int N = 5;
  localparam logic [63:0] CORE_NAME = `NTS_CORE_NAME;

  // Counter order is frames, good, bad, dispatched, bytes
  localparam logic [`NTS_API_ADDR_WIDTH-1:0] MSB_ADDR [N] = '{`NTS_ADDR_FRAMES_MSB,
    `NTS_ADDR_GOOD_MSB, `NTS_ADDR_BAD_MSB, `NTS_ADDR_DISPATCHED_MSB, `NTS_ADDR_BYTES_RX_MSB};
  localparam logic [`NTS_API_ADDR_WIDTH-1:0] LSB_ADDR [N] = '{`NTS_ADDR_FRAMES_LSB,
    `NTS_ADDR_GOOD_LSB, `NTS_ADDR_BAD_LSB, `NTS_ADDR_DISPATCHED_LSB, `NTS_ADDR_BYTES_RX_LSB};

  logic [63:0]  count [N];
  logic [31:0]  lsb   [N];
  logic [63:0]  inc   [N];
  logic [N-1:0] snap;        // LSB latch on an MSB read

  assign inc[0] = {63'd0, i_start_of_frame};
  assign inc[1] = {63'd0, i_beat.good_frame};
  assign inc[2] = {63'd0, i_beat.bad_frame};
  assign inc[3] = {63'd0, i_rd_start};
  assign inc[4] = {60'd0, i_bytes};

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < N; i++)
      begin
        count[i] <= '0;
        lsb[i]   <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < N; i++)
      begin
        count[i] <= count[i] + inc[i];
        if (snap[i])
          lsb[i] <= count[i][31:0];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read window
  // ------------------------------------------------------------------------
  always_comb
  begin
    o_api_read_data = '0;
    snap            = '0;
    if (i_api_cs)
    begin
      case (i_api_address)
        `NTS_ADDR_NAME0:   o_api_read_data = CORE_NAME[63:32];
        `NTS_ADDR_NAME1:   o_api_read_data = CORE_NAME[31:0];
        `NTS_ADDR_VERSION: o_api_read_data = `NTS_CORE_VERSION;
        default:           o_api_read_data = '0;
      endcase
      for (int i = 0; i < N; i++)
      begin
        if (i_api_address == MSB_ADDR[i])
        begin
          o_api_read_data = count[i][63:32];
          snap[i]         = 1'b1;
        end
        if (i_api_address == LSB_ADDR[i])
          o_api_read_data = lsb[i];
      end
    end
  end

endmodule

/* rtl/nts_dispatcher.sv */
/*
 * Frame dispatcher top: receive capture, ping-pong frame store with
 * its dispatch reader, and the statistics register window
 */
`include "nts_dispatcher_params.svh"

module nts_dispatcher (
  input  logic                                i_clk,
  input  logic                                i_areset,
  input  nts_dispatcher_pkg::rx_beat_t        i_beat,
  input  logic                                i_rd_start,
  input  logic                                i_read_discard,
  input  logic                                i_api_cs,
  input  logic [`NTS_API_ADDR_WIDTH-1:0]      i_api_address,
  output logic                                o_packet_available,
  output nts_dispatcher_pkg::frame_info_t     o_frame_info,
  output logic                                o_fifo_empty,
  output nts_dispatcher_pkg::dispatch_word_t  o_dispatch_word,
  output logic [31:0]                         o_api_read_data
);

  nts_dispatcher_pkg::bank_write_t bank_write;
  nts_dispatcher_pkg::frame_info_t commit_info;
  logic                            commit;
  logic                            abort;
  logic                            wr_ready;
  logic                            start_of_frame;
  logic [3:0]                      rx_bytes;

  nts_rx_capture u_capture (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_beat           (i_beat),
    .i_wr_ready       (wr_ready),
    .o_write          (bank_write),
    .o_commit         (commit),
    .o_abort          (abort),
    .o_info           (commit_info),
    .o_start_of_frame (start_of_frame),
    .o_bytes          (rx_bytes)
  );

  nts_frame_store u_store (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_write            (bank_write),
    .i_commit           (commit),
    .i_abort            (abort),
    .i_info             (commit_info),
    .i_rd_start         (i_rd_start),
    .i_read_discard     (i_read_discard),
    .o_wr_ready         (wr_ready),
    .o_packet_available (o_packet_available),
    .o_frame_info       (o_frame_info),
    .o_fifo_empty       (o_fifo_empty),
    .o_word             (o_dispatch_word)
  );

  nts_rx_statistics u_stats (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_beat           (i_beat),
    .i_start_of_frame (start_of_frame),
    .i_bytes          (rx_bytes),
    .i_rd_start       (i_rd_start),
    .i_api_cs         (i_api_cs),
    .i_api_address    (i_api_address),
    .o_api_read_data  (o_api_read_data)
  );

endmodule

/* bench/nts_dispatcher_props.sv */
/*
 * Concurrent checks on the frame store outputs and write handshake,
 * bound into every frame store instance
 */

module nts_dispatcher_props (
  input  logic i_clk,
  input  logic i_areset,
  input  logic i_write_strobe,
  input  logic i_wr_ready,
  input  logic i_packet_available,
  input  logic i_fifo_empty,
  input  logic i_word_valid
);

  logic fail_empty = 1'b0;
  logic fail_reset = 1'b0;
  logic fail_ready = 1'b0;
  logic any_fail;

  assign any_fail = fail_empty | fail_reset | fail_ready;  // Watched by the testbench

  // No word goes out of an empty FIFO
  a_valid_not_empty: assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_word_valid && i_fifo_empty))
  else
  begin
    fail_empty = 1'b1;
    $error("Dispatch word valid while the FIFO reads empty");
  end

  a_idle_after_reset: assert property (@(posedge i_clk)
    $fell(i_areset) |-> (!i_packet_available && !i_word_valid))
  else
  begin
    fail_reset = 1'b1;
    $error("Packet available or word valid right after reset");
  end

  // A new write burst only starts into a bank that can take it
  a_strobe_needs_ready: assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(i_write_strobe) |-> i_wr_ready)
  else
  begin
    fail_ready = 1'b1;
    $error("Bank write strobe rose while the write bank was not ready");
  end

endmodule

bind nts_frame_store nts_dispatcher_props u_props (
  .i_clk              (i_clk),
  .i_areset           (i_areset),
  .i_write_strobe     (i_write.strobe),
  .i_wr_ready         (o_wr_ready),
  .i_packet_available (o_packet_available),
  .i_fifo_empty       (o_fifo_empty),
  .i_word_valid       (o_word.valid)
);

/* bench/tb_nts_dispatcher.sv */
/*
 * Frame dispatcher testbench: random MAC frames, reference alignment,
 * word comparison process, counter and identity register checks
 */
`include "nts_dispatcher_params.svh"

module tb_nts_dispatcher;

  localparam int          WAIT_LIMIT   = 200;
  localparam int          QUIET_CYCLES = 50;
  localparam logic [63:0] CORE_NAME    = `NTS_CORE_NAME;

  logic                               i_clk = 1'b0;
  logic                               i_areset;
  nts_dispatcher_pkg::rx_beat_t       i_beat;
  logic                               i_rd_start;
  logic                               i_read_discard;
  logic                               i_api_cs;
  logic [`NTS_API_ADDR_WIDTH-1:0]     i_api_address;
  logic                               o_packet_available;
  nts_dispatcher_pkg::frame_info_t    o_frame_info;
  logic                               o_fifo_empty;
  nts_dispatcher_pkg::dispatch_word_t o_dispatch_word;
  logic [31:0]                        o_api_read_data;

  int          seed = 29;
  int          words_seen = 0;
  logic [63:0] expected_q [$];    // Aligned words still to come out
  logic [63:0] frames_count = '0;
  logic [63:0] good_count = '0;
  logic [63:0] bad_count = '0;
  logic [63:0] disp_count = '0;
  logic [63:0] bytes_count = '0;

  always #5 i_clk = ~i_clk;

  nts_dispatcher UUT (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_beat             (i_beat),
    .i_rd_start         (i_rd_start),
    .i_read_discard     (i_read_discard),
    .i_api_cs           (i_api_cs),
    .i_api_address      (i_api_address),
    .o_packet_available (o_packet_available),
    .o_frame_info       (o_frame_info),
    .o_fifo_empty       (o_fifo_empty),
    .o_dispatch_word    (o_dispatch_word),
    .o_api_read_data    (o_api_read_data)
  );

  // ------------------------------------------------------------------------
  // Reference model and checks
  // ------------------------------------------------------------------------
  // n valid low bytes end up as the top n bytes
  function automatic logic [63:0] align_word(input logic [63:0] data, input logic [7:0] mask);
    logic [63:0] result;
    int          n;
    result = '0;
    n      = 0;
    for (int b = 0; b < 8; b++)
      if (mask[b])
        n++;
    for (int b = 0; b < n; b++)
      result[(8 - n + b) * 8 +: 8] = data[b * 8 +: 8];
    return result;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  always @(negedge i_clk)
  begin
    if (!i_areset && o_dispatch_word.valid)
    begin
      if (expected_q.size() == 0)
        stop_on_error("A dispatch word came out while no word was expected");
      else
      begin
        check_value("o_dispatch_word.data", o_dispatch_word.data, expected_q.pop_front());
        words_seen++;
      end
    end
    if (UUT.u_store.u_props.any_fail)
      stop_on_error("A concurrent assertion on the frame store failed");
  end

  // ------------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------------
  task automatic tick();
    @(posedge i_clk);
    #1;
  endtask

  // Idle beat, then the frame, then idle again
  task automatic send_frame(input logic bad, output int len, output logic [7:0] mask);
    logic [63:0] data;
    int          n;
    len = 1 + ($unsigned($random(seed)) % 20);
    n   = 1 + ($unsigned($random(seed)) % 8);
    if (len == 1)
      n = 8;                     // Start beat must be full
    mask = 8'hff >> (8 - n);
    tick();
    i_beat = '0;
    for (int i = 0; i < len; i++)
    begin
      tick();
      data            = {$random(seed), $random(seed)};
      i_beat.data     = data;
      i_beat.data_valid = (i == len - 1) ? mask : 8'hff;
      i_beat.good_frame = (i == len - 1) && !bad;
      i_beat.bad_frame  = (i == len - 1) && bad;
      bytes_count      += (i == len - 1) ? n : 8;
      if (!bad)
        expected_q.push_back(align_word(data, i_beat.data_valid));
    end
    tick();
    i_beat = '0;
    frames_count++;
    if (bad)
      bad_count++;
    else
      good_count++;
  endtask

  task automatic wait_available();
    int cycles;
    cycles = 0;
    while (!o_packet_available)
    begin
      if (cycles == WAIT_LIMIT)
        stop_on_error("Timed out waiting for a frame to become available");
      tick();
      cycles++;
    end
  endtask

  task automatic read_frame(input int len, input logic [7:0] mask);
    int cycles;
    int target;
    wait_available();
    check_value("o_frame_info.last_addr", o_frame_info.last_addr, len - 1);
    check_value("o_frame_info.data_valid", o_frame_info.data_valid, mask);
    i_rd_start = 1'b1;
    disp_count++;
    tick();
    i_rd_start = 1'b0;
    target = words_seen + len;
    cycles = 0;
    while (words_seen < target || !o_fifo_empty)
    begin
      if (cycles == WAIT_LIMIT)
        stop_on_error("Timed out waiting for the frame to be read out");
      tick();
      cycles++;
    end
    i_read_discard = 1'b1;  // Hand the bank back
    tick();
    i_read_discard = 1'b0;
  endtask

  task automatic read_reg(input logic [`NTS_API_ADDR_WIDTH-1:0] addr, output logic [31:0] value);
    tick();
    i_api_cs      = 1'b1;
    i_api_address = addr;
    @(negedge i_clk);
    value = o_api_read_data;
    tick();
    i_api_cs = 1'b0;
  endtask

  // MSB read latches the LSB, so the order matters
  task automatic read_counter(input logic [`NTS_API_ADDR_WIDTH-1:0] msb_addr,
                              input logic [`NTS_API_ADDR_WIDTH-1:0] lsb_addr,
                              output logic [63:0] value);
    logic [31:0] hi;
    logic [31:0] lo;
    read_reg(msb_addr, hi);
    read_reg(lsb_addr, lo);
    value = {hi, lo};
  endtask

  task automatic check_counter(input string name, input logic [`NTS_API_ADDR_WIDTH-1:0] msb_addr,
                               input logic [`NTS_API_ADDR_WIDTH-1:0] lsb_addr,
                               input logic [63:0] exp);
    logic [63:0] got;
    read_counter(msb_addr, lsb_addr, got);
    check_value(name, got, exp);
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial
  begin
    int          len_a;
    int          len_b;
    logic [7:0]  mask_a;
    logic [7:0]  mask_b;
    logic [63:0] bad_before;
    logic [63:0] bad_after;
    logic [31:0] word;
    i_areset       = 1'b1;
    i_beat         = '0;
    i_rd_start     = 1'b0;
    i_read_discard = 1'b0;
    i_api_cs       = 1'b0;
    i_api_address  = '0;
    repeat (10) @(posedge i_clk);
    #1 i_areset = 1'b0;

    // Single good frame
    send_frame(1'b0, len_a, mask_a);
    read_frame(len_a, mask_a);

    // Bad frame never shows up
    read_counter(`NTS_ADDR_BAD_MSB, `NTS_ADDR_BAD_LSB, bad_before);
    check_value("bad frame counter", bad_before, bad_count);
    send_frame(1'b1, len_a, mask_a);
    for (int i = 0; i < QUIET_CYCLES; i++)
    begin
      tick();
      if (o_packet_available)
        stop_on_error("A frame became available after a bad frame");
    end
    read_counter(`NTS_ADDR_BAD_MSB, `NTS_ADDR_BAD_LSB, bad_after);
    check_value("bad frame counter", bad_after, bad_count);

    // Both banks filled before any read
    send_frame(1'b0, len_a, mask_a);
    send_frame(1'b0, len_b, mask_b);
    read_frame(len_a, mask_a);
    read_frame(len_b, mask_b);

    for (int k = 0; k < 4; k++)
    begin
      send_frame(k == 2, len_a, mask_a);
      if (k != 2)
        read_frame(len_a, mask_a);
    end

    check_counter("frames counter", `NTS_ADDR_FRAMES_MSB, `NTS_ADDR_FRAMES_LSB, frames_count);
    check_counter("good counter", `NTS_ADDR_GOOD_MSB, `NTS_ADDR_GOOD_LSB, good_count);
    check_counter("bad counter", `NTS_ADDR_BAD_MSB, `NTS_ADDR_BAD_LSB, bad_count);
    check_counter("dispatched counter", `NTS_ADDR_DISPATCHED_MSB, `NTS_ADDR_DISPATCHED_LSB,
                  disp_count);
    check_counter("bytes counter", `NTS_ADDR_BYTES_RX_MSB, `NTS_ADDR_BYTES_RX_LSB, bytes_count);

    read_reg(`NTS_ADDR_NAME0, word);
    check_value("core name word 0", word, CORE_NAME[63:32]);
    read_reg(`NTS_ADDR_NAME1, word);
    check_value("core name word 1", word, CORE_NAME[31:0]);
    read_reg(`NTS_ADDR_VERSION, word);
    check_value("core version", word, `NTS_CORE_VERSION);
    check_value("words left in queue", expected_q.size(), 0);

    $display("Test passed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/nts_dispatcher_pkg.sv
rtl/nts_rx_capture.sv
rtl/frame_store/nts_dispatch_reader.sv
rtl/frame_store/nts_frame_store.sv
rtl/nts_rx_statistics.sv
rtl/nts_dispatcher.sv
bench/nts_dispatcher_props.sv
bench/tb_nts_dispatcher.sv

/* Bender.yml */
package:
  name: nts_dispatcher

sources:
  - include_dirs:
      - common
    files:
      - common/nts_dispatcher_pkg.sv
      - rtl/nts_rx_capture.sv
      - rtl/frame_store/nts_dispatch_reader.sv
      - rtl/frame_store/nts_frame_store.sv
      - rtl/nts_rx_statistics.sv
      - rtl/nts_dispatcher.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/nts_dispatcher_props.sv
      - bench/tb_nts_dispatcher.sv
